// ==== all.f ====
+incdir+design
design/alloc_pkg.sv
design/alloc_ptr_pool.sv
design/alloc_ctrl_regs.sv
design/alloc_mon_core.sv
design/alloc_top.sv
verif/alloc_chk.sv
verif/alloc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the allocator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module alloc_tb -f all.f -o alloc_sim

output=$(./obj_dir/alloc_sim) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "No errors"

// ==== verif/alloc_tb.sv ====
/*
 * Allocator testbench
 * Clock and reset, register and pool tasks, reference model, directed tests
 */
`timescale 1ns/1ns
`default_nettype none

`include "alloc_cfg.svh"

module alloc_tb;

    import alloc_pkg::*;

    localparam int TIMEOUT = 64;
    localparam int N_PTRS  = `ALLOC_MAX_PTRS;

    logic                       clk;
    logic                       dbg_cnt_reset;
    logic                       en;
    logic                       alloc_req;
    logic                       dealloc_req;
    logic [`ALLOC_PTR_WID-1:0]  dealloc_ptr;
    logic                       reg_wr;
    logic                       reg_rd;
    alloc_reg_addr_e            reg_addr;
    logic [31:0]                reg_wdata;
    logic                       alloc_valid;
    logic                       alloc_fail;
    logic [`ALLOC_PTR_WID-1:0]  alloc_ptr;
    logic [31:0]                reg_rdata;
    logic                       reg_rvalid;

    // Pool event pulses observed inside the DUT
    logic pool_ev_alloc_err;
    logic pool_ev_dealloc;
    logic pool_ev_dealloc_fail;
    logic pool_ev_dealloc_err;

    // --------------------
    // Reference model
    // --------------------
    bit          model_free [N_PTRS];
    bit          model_run;
    bit          model_alloc_en;
    int          n_alloc;
    int          n_alloc_fail;
    int          n_alloc_err;
    int          n_dealloc;
    int          n_dealloc_fail;
    int          n_dealloc_err;
    int          n_active;
    int          err_cnt;
    int          check_cnt;
    logic [31:0] lcg_state;

    alloc_top alloc_top_inst (
        .clk           (clk),
        .dbg_cnt_reset (dbg_cnt_reset),
        .en            (en),
        .alloc_req     (alloc_req),
        .dealloc_req   (dealloc_req),
        .dealloc_ptr   (dealloc_ptr),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .alloc_valid   (alloc_valid),
        .alloc_fail    (alloc_fail),
        .alloc_ptr     (alloc_ptr),
        .reg_rdata     (reg_rdata),
        .reg_rvalid    (reg_rvalid)
    );

    assign pool_ev_alloc_err    = alloc_top_inst.alloc_ptr_pool_inst.ev_alloc_err;
    assign pool_ev_dealloc      = alloc_top_inst.alloc_ptr_pool_inst.ev_dealloc;
    assign pool_ev_dealloc_fail = alloc_top_inst.alloc_ptr_pool_inst.ev_dealloc_fail;
    assign pool_ev_dealloc_err  = alloc_top_inst.alloc_ptr_pool_inst.ev_dealloc_err;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        err_cnt++;
        $display("%s", msg);
    endtask

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'({17'd0, lcg_state[30:16]});
    endfunction

    function automatic int lowest_free();
        for (int i = 0; i < N_PTRS; i++) begin
            if (model_free[i]) return i;
        end
        return -1;
    endfunction

    // Random pointer among the ones handed out
    function automatic int pick_used();
        int used_q[$];
        for (int i = 0; i < N_PTRS; i++) begin
            if (!model_free[i]) used_q.push_back(i);
        end
        return used_q[next_rand() % used_q.size()];
    endfunction

    task automatic model_reset();
        for (int i = 0; i < N_PTRS; i++) begin
            model_free[i] = 1'b1;
        end
        model_run      = 1'b0;
        n_alloc        = 0;
        n_alloc_fail   = 0;
        n_alloc_err    = 0;
        n_dealloc      = 0;
        n_dealloc_fail = 0;
        n_dealloc_err  = 0;
        n_active       = 0;
    endtask

    // --------------------
    // Register port
    // --------------------
    task automatic reg_write(input alloc_reg_addr_e addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        next_cycle();
        reg_wr    = 1'b0;
    endtask

    task automatic reg_read(input alloc_reg_addr_e addr, output logic [31:0] data);
        int waited;
        // Give the previous cycle's pulses time to reach the monitor
        next_cycle();
        reg_rd   = 1'b1;
        reg_addr = addr;
        next_cycle();
        reg_rd   = 1'b0;
        waited   = 0;
        while (!reg_rvalid && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!reg_rvalid) begin
            report_problem($sformatf("Timeout waiting for reg_rvalid on a read of %s",
                                     addr.name()));
            data = '0;
        end else begin
            data = reg_rdata;
        end
    endtask

    task automatic reg_read_check(input alloc_reg_addr_e addr, input logic [31:0] exp);
        logic [31:0] data;
        reg_read(addr, data);
        check_value($sformatf("read of %s", addr.name()), data, exp);
    endtask

    // Done once init_done is up and the reset pulse is gone
    task automatic wait_init();
        logic [31:0] data;
        int          polls;
        bit          done;
        polls = 0;
        done  = 1'b0;
        while (!done && polls < TIMEOUT) begin
            reg_read(REG_STATUS, data);
            done = data[1] && !data[0];
            polls++;
        end
        if (!done) report_problem("Timeout waiting for init_done in REG_STATUS");
        model_run = 1'b1;
    endtask

    // Poll the allocator state code until it shows the wanted state
    task automatic wait_state(input alloc_state_e want);
        logic [31:0] data;
        int          polls;
        polls = 0;
        data  = '1;
        while (data != 32'(want) && polls < TIMEOUT) begin
            reg_read(REG_DBG_STATUS, data);
            polls++;
        end
        if (data != 32'(want)) begin
            report_problem($sformatf("Timeout waiting for the pool to reach %s",
                                     want.name()));
        end
    endtask

    // --------------------
    // Pool requests
    // --------------------
    task automatic do_alloc();
        int exp_ptr;
        bit exp_valid;
        bit exp_fail;
        bit exp_err;
        exp_ptr   = -1;
        exp_valid = 1'b0;
        exp_fail  = 1'b0;
        exp_err   = 1'b0;
        if (!model_run || !model_alloc_en) begin
            exp_err = 1'b1;
            n_alloc_err++;
        end else begin
            exp_ptr = lowest_free();
            if (exp_ptr < 0) begin
                exp_fail = 1'b1;
                n_alloc_fail++;
            end else begin
                exp_valid = 1'b1;
                model_free[exp_ptr] = 1'b0;
                n_alloc++;
                n_active++;
            end
        end
        alloc_req = 1'b1;
        next_cycle();
        alloc_req = 1'b0;
        check_value("alloc_valid", 32'(alloc_valid), 32'(exp_valid));
        check_value("alloc_fail", 32'(alloc_fail), 32'(exp_fail));
        check_value("ev_alloc_err", 32'(pool_ev_alloc_err), 32'(exp_err));
        if (exp_valid) check_value("alloc_ptr", 32'(alloc_ptr), exp_ptr);
    endtask

    task automatic do_dealloc(input int ptr);
        bit exp_ok;
        bit exp_off;
        bit exp_dup;
        exp_ok  = 1'b0;
        exp_off = 1'b0;
        exp_dup = 1'b0;
        if (!model_run) begin
            exp_off = 1'b1;
            n_dealloc_fail++;
        end else if (model_free[ptr]) begin
            exp_dup = 1'b1;
            n_dealloc_err++;
        end else begin
            exp_ok = 1'b1;
            model_free[ptr] = 1'b1;
            n_dealloc++;
            n_active--;
        end
        dealloc_req = 1'b1;
        dealloc_ptr = `ALLOC_PTR_WID'(ptr);
        next_cycle();
        dealloc_req = 1'b0;
        check_value("ev_dealloc", 32'(pool_ev_dealloc), 32'(exp_ok));
        check_value("ev_dealloc_fail", 32'(pool_ev_dealloc_fail), 32'(exp_off));
        check_value("ev_dealloc_err", 32'(pool_ev_dealloc_err), 32'(exp_dup));
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_bring_up();
        reg_write(REG_CONTROL, 32'h6);
        model_alloc_en = 1'b1;
        wait_init();
        reg_read_check(REG_INFO_SIZE, N_PTRS);
        reg_read_check(REG_STATUS, 32'h6);
    endtask

    task automatic test_fill_pool();
        // Pointers come out lowest first until the pool runs dry
        repeat (N_PTRS) do_alloc();
        do_alloc();
        reg_read_check(REG_CNT_ACTIVE, N_PTRS);
    endtask

    task automatic test_free_and_reuse();
        repeat (5) do_dealloc(pick_used());
        reg_read_check(REG_CNT_ACTIVE, n_active);
        repeat (5) do_alloc();
        reg_read_check(REG_CNT_ACTIVE, n_active);
    endtask

    task automatic test_error_paths();
        int ptr;
        ptr = pick_used();
        do_dealloc(ptr);
        do_dealloc(ptr);
        reg_read_check(REG_DEALLOC_ERR_PTR, ptr);
        reg_write(REG_CONTROL, 32'h2);
        model_alloc_en = 1'b0;
        do_alloc();
        reg_read_check(REG_ALLOC_ERR_PTR, 0);
        // Flags clear on read
        reg_read_check(REG_STATUS_FLAGS, 32'h3);
        reg_read_check(REG_STATUS_FLAGS, 32'h0);
        reg_write(REG_CONTROL, 32'h6);
        model_alloc_en = 1'b1;

        // Dealloc is refused while the pool is disabled
        en = 1'b0;
        wait_state(ST_DISABLED);
        model_run = 1'b0;
        do_dealloc(pick_used());
        en = 1'b1;
        wait_state(ST_RUN);
        model_run = 1'b1;
    endtask

    task automatic test_debug_counters();
        reg_read_check(REG_DBG_CNT_ALLOC, n_alloc);
        reg_read_check(REG_DBG_CNT_ALLOC_FAIL, n_alloc_fail);
        reg_read_check(REG_DBG_CNT_ALLOC_ERR, n_alloc_err);
        reg_read_check(REG_DBG_CNT_DEALLOC, n_dealloc);
        reg_read_check(REG_DBG_CNT_DEALLOC_FAIL, n_dealloc_fail);
        reg_read_check(REG_DBG_CNT_DEALLOC_ERR, n_dealloc_err);
        reg_write(REG_DBG_CONTROL, 32'h1);
        reg_read_check(REG_DBG_CNT_ALLOC, 0);
        reg_read_check(REG_DBG_CNT_ALLOC_FAIL, 0);
        reg_read_check(REG_DBG_CNT_ALLOC_ERR, 0);
        reg_read_check(REG_DBG_CNT_DEALLOC, 0);
        reg_read_check(REG_DBG_CNT_DEALLOC_FAIL, 0);
        reg_read_check(REG_DBG_CNT_DEALLOC_ERR, 0);
        reg_read_check(REG_CNT_ACTIVE, n_active);
    endtask

    task automatic test_function_reset();
        int ptr;
        // Leave a sticky flag behind for the reset to clear
        ptr = lowest_free();
        do_dealloc(ptr);
        reg_write(REG_CONTROL, 32'h7);
        model_reset();
        wait_init();
        reg_read_check(REG_CNT_ACTIVE, 0);
        reg_read_check(REG_STATUS_FLAGS, 0);
        do_alloc();
        reg_read_check(REG_CNT_ACTIVE, n_active);
        reg_read_check(REG_DBG_CNT_ALLOC, n_alloc);
    endtask

    initial begin
        int assert_fails;
        err_cnt        = 0;
        check_cnt      = 0;
        lcg_state      = 32'd52623;
        model_alloc_en = 1'b0;
        dbg_cnt_reset  = 1'b1;
        en             = 1'b1;
        alloc_req      = 1'b0;
        dealloc_req    = 1'b0;
        dealloc_ptr    = '0;
        reg_wr         = 1'b0;
        reg_rd         = 1'b0;
        reg_addr       = REG_CONTROL;
        reg_wdata      = '0;
        model_reset();
        repeat (3) @(posedge clk);
        #1;
        dbg_cnt_reset = 1'b0;

        test_bring_up();
        test_fill_pool();
        test_free_and_reuse();
        test_error_paths();
        test_debug_counters();
        test_function_reset();

        assert_fails = alloc_top_inst.alloc_ptr_pool_inst.alloc_chk_inst.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_cnt, err_cnt, assert_fails);
        if (err_cnt == 0 && assert_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : alloc_tb

`default_nettype wire

// ==== verif/alloc_chk.sv ====
/*
 * Allocator pool checker
 * Concurrent assertions on result pulses, state and init flag
 */
`timescale 1ns/1ns
`default_nettype none

module alloc_chk (
    input  wire logic               clk,
    input  wire logic               dbg_cnt_reset,
    input  wire logic               alloc_valid,
    input  wire logic               alloc_fail,
    input  wire logic               ev_alloc,
    input  wire logic               ev_dealloc,
    input  wire logic               init_done,
    input  alloc_pkg::alloc_state_e state
);

    import alloc_pkg::*;

    // Number of failed assertions, read by the testbench
    int fail_cnt = 0;

    // A request either succeeds or fails, never both
    valid_fail_excl: assert property (@(posedge clk) disable iff (dbg_cnt_reset)
        !(alloc_valid && alloc_fail))
    else begin
        fail_cnt++;
        $error("alloc_valid and alloc_fail high in the same cycle");
    end

    // Success pulses only for requests taken while running
    pulse_in_run: assert property (@(posedge clk) disable iff (dbg_cnt_reset)
        (ev_alloc || ev_dealloc || alloc_valid) |-> ($past(state) == ST_RUN))
    else begin
        fail_cnt++;
        $error("Alloc or dealloc pulse for a request outside ST_RUN");
    end

    init_low_in_sweep: assert property (@(posedge clk) disable iff (dbg_cnt_reset)
        (state == ST_INIT) |-> !init_done)
    else begin
        fail_cnt++;
        $error("init_done high while the pool is in ST_INIT");
    end

endmodule : alloc_chk

bind alloc_ptr_pool alloc_chk alloc_chk_inst (
    .clk           (clk),
    .dbg_cnt_reset (dbg_cnt_reset),
    .alloc_valid   (alloc_valid),
    .alloc_fail    (alloc_fail),
    .ev_alloc      (ev_alloc),
    .ev_dealloc    (ev_dealloc),
    .init_done     (init_done),
    .state         (state)
);

`default_nettype wire

// ==== design/alloc_top.sv ====
/*
 * Allocator top level
 * Control registers, pointer pool and monitor core
 */
`timescale 1ns/1ns
`default_nettype none

`include "alloc_cfg.svh"

module alloc_top (
    input  wire logic                       clk,
    input  wire logic                       dbg_cnt_reset,
    input  wire logic                       en,
    input  wire logic                       alloc_req,
    input  wire logic                       dealloc_req,
    input  wire logic [`ALLOC_PTR_WID-1:0]  dealloc_ptr,
    input  wire logic                       reg_wr,
    input  wire logic                       reg_rd,
    input  alloc_pkg::alloc_reg_addr_e      reg_addr,
    input  wire logic [31:0]                reg_wdata,
    output logic                            alloc_valid,
    output logic                            alloc_fail,
    output logic [`ALLOC_PTR_WID-1:0]       alloc_ptr,
    output logic [31:0]                     reg_rdata,
    output logic                            reg_rvalid
);

    import alloc_pkg::*;

    // Control
    logic ctrl_reset;
    logic ctrl_en;
    logic ctrl_alloc_en;
    logic dbg_clear;
    logic enable_bit;

    // Allocator events and status
    logic                       ev_alloc;
    logic                       ev_alloc_fail;
    logic                       ev_alloc_err;
    logic                       ev_dealloc;
    logic                       ev_dealloc_fail;
    logic                       ev_dealloc_err;
    logic [`ALLOC_PTR_WID-1:0]  ev_ptr;
    logic                       init_done;
    alloc_state_e               state;

    alloc_ctrl_regs alloc_ctrl_regs_inst (
        .clk           (clk),
        .dbg_cnt_reset (dbg_cnt_reset),
        .en            (en),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .ctrl_reset    (ctrl_reset),
        .ctrl_en       (ctrl_en),
        .ctrl_alloc_en (ctrl_alloc_en),
        .dbg_clear     (dbg_clear),
        .enable_bit    (enable_bit)
    );

    alloc_ptr_pool alloc_ptr_pool_inst (
        .clk             (clk),
        .dbg_cnt_reset   (dbg_cnt_reset),
        .ctrl_reset      (ctrl_reset),
        .ctrl_en         (ctrl_en),
        .ctrl_alloc_en   (ctrl_alloc_en),
        .alloc_req       (alloc_req),
        .dealloc_req     (dealloc_req),
        .dealloc_ptr     (dealloc_ptr),
        .alloc_valid     (alloc_valid),
        .alloc_fail      (alloc_fail),
        .alloc_ptr       (alloc_ptr),
        .ev_alloc        (ev_alloc),
        .ev_alloc_fail   (ev_alloc_fail),
        .ev_alloc_err    (ev_alloc_err),
        .ev_dealloc      (ev_dealloc),
        .ev_dealloc_fail (ev_dealloc_fail),
        .ev_dealloc_err  (ev_dealloc_err),
        .ev_ptr          (ev_ptr),
        .init_done       (init_done),
        .state           (state)
    );

    alloc_mon_core alloc_mon_core_inst (
        .clk             (clk),
        .dbg_cnt_reset   (dbg_cnt_reset),
        .ctrl_reset      (ctrl_reset),
        .dbg_clear       (dbg_clear),
        .ctrl_en         (ctrl_en),
        .enable_bit      (enable_bit),
        .ctrl_alloc_en   (ctrl_alloc_en),
        .init_done       (init_done),
        .state           (state),
        .ev_alloc        (ev_alloc),
        .ev_alloc_fail   (ev_alloc_fail),
        .ev_alloc_err    (ev_alloc_err),
        .ev_dealloc      (ev_dealloc),
        .ev_dealloc_fail (ev_dealloc_fail),
        .ev_dealloc_err  (ev_dealloc_err),
        .ev_ptr          (ev_ptr),
        .reg_rd          (reg_rd),
        .reg_addr        (reg_addr),
        .reg_rdata       (reg_rdata),
        .reg_rvalid      (reg_rvalid)
    );

endmodule : alloc_top

`default_nettype wire

// ==== design/alloc_mon_core.sv ====
/*
 * Monitor core
 * Active count, clear-on-read flags, error pointers, debug counters
 * and the registered read multiplexer
 */
`timescale 1ns/1ns
`default_nettype none

`include "alloc_cfg.svh"

module alloc_mon_core (
    input  wire logic                       clk,
    input  wire logic                       dbg_cnt_reset,
    input  wire logic                       ctrl_reset,
    input  wire logic                       dbg_clear,
    input  wire logic                       ctrl_en,
    input  wire logic                       enable_bit,
    input  wire logic                       ctrl_alloc_en,
    input  wire logic                       init_done,
    input  alloc_pkg::alloc_state_e         state,
    input  wire logic                       ev_alloc,
    input  wire logic                       ev_alloc_fail,
    input  wire logic                       ev_alloc_err,
    input  wire logic                       ev_dealloc,
    input  wire logic                       ev_dealloc_fail,
    input  wire logic                       ev_dealloc_err,
    input  wire logic [`ALLOC_PTR_WID-1:0]  ev_ptr,
    input  wire logic                       reg_rd,
    input  alloc_pkg::alloc_reg_addr_e      reg_addr,
    output logic [31:0]                     reg_rdata,
    output logic                            reg_rvalid
);

    import alloc_pkg::*;

    // Debug counter slots, in register map order
    localparam int N_CNT = 6;

    logic [`ALLOC_PTR_WID:0]    cnt_active;
    logic                       flag_alloc_err;
    logic                       flag_dealloc_err;
    logic                       flags_rd;
    logic [`ALLOC_PTR_WID-1:0]  alloc_err_ptr;
    logic [`ALLOC_PTR_WID-1:0]  dealloc_err_ptr;
    logic [N_CNT-1:0]           ev_vec;
    logic [`ALLOC_CNT_WID-1:0]  dbg_cnt [N_CNT];
    logic [31:0]                rd_mux;

    // --------------------
    // Active count
    // --------------------
    // A simultaneous alloc and dealloc leaves the count unchanged
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset || ctrl_reset) begin
            cnt_active <= '0;
        end else if (ev_alloc && !ev_dealloc) begin
            cnt_active <= cnt_active + 1'b1;
        end else if (ev_dealloc && !ev_alloc) begin
            cnt_active <= cnt_active - 1'b1;
        end
    end

    // --------------------
    // Sticky flags
    // --------------------
    assign flags_rd = reg_rd && (reg_addr == REG_STATUS_FLAGS);

    // On a read, reload with this cycle's events only
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset || ctrl_reset) begin
            flag_alloc_err   <= 1'b0;
            flag_dealloc_err <= 1'b0;
        end else if (flags_rd) begin
            flag_alloc_err   <= ev_alloc_err;
            flag_dealloc_err <= ev_dealloc_err;
        end else begin
            flag_alloc_err   <= flag_alloc_err || ev_alloc_err;
            flag_dealloc_err <= flag_dealloc_err || ev_dealloc_err;
        end
    end

    // Pointer captured at the most recent error of each kind
    always_ff @(posedge clk) begin
        if (ev_alloc_err)   alloc_err_ptr   <= ev_ptr;
        if (ev_dealloc_err) dealloc_err_ptr <= ev_ptr;
    end

    // --------------------
    // Debug counters
    // --------------------
    assign ev_vec = {ev_dealloc_err, ev_dealloc_fail, ev_dealloc,
                     ev_alloc_err, ev_alloc_fail, ev_alloc};

    // Wrap around on overflow
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_CNT; i++) begin
            if (dbg_cnt_reset || dbg_clear) begin
                dbg_cnt[i] <= '0;
            end else if (ev_vec[i]) begin
                dbg_cnt[i] <= dbg_cnt[i] + 1'b1;
            end
        end
    end

    // --------------------
    // Read multiplexer
    // --------------------
    always_comb begin
        case (reg_addr)
            REG_CONTROL:              rd_mux = {29'b0, ctrl_alloc_en, enable_bit, 1'b0};
            REG_STATUS:               rd_mux = {29'b0, ctrl_en, init_done, ctrl_reset};
            REG_STATUS_FLAGS:         rd_mux = {30'b0, flag_dealloc_err, flag_alloc_err};
            REG_ALLOC_ERR_PTR:        rd_mux = 32'(alloc_err_ptr);
            REG_DEALLOC_ERR_PTR:      rd_mux = 32'(dealloc_err_ptr);
            REG_CNT_ACTIVE:           rd_mux = 32'(cnt_active);
            REG_DBG_STATUS:           rd_mux = 32'(state);
            REG_INFO_SIZE:            rd_mux = 32'(`ALLOC_MAX_PTRS);
            REG_DBG_CNT_ALLOC:        rd_mux = 32'(dbg_cnt[0]);
            REG_DBG_CNT_ALLOC_FAIL:   rd_mux = 32'(dbg_cnt[1]);
            REG_DBG_CNT_ALLOC_ERR:    rd_mux = 32'(dbg_cnt[2]);
            REG_DBG_CNT_DEALLOC:      rd_mux = 32'(dbg_cnt[3]);
            REG_DBG_CNT_DEALLOC_FAIL: rd_mux = 32'(dbg_cnt[4]);
            REG_DBG_CNT_DEALLOC_ERR:  rd_mux = 32'(dbg_cnt[5]);
            // Debug control is write-only, unmapped words read zero
            default:                  rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) reg_rdata <= rd_mux;
    end

endmodule : alloc_mon_core

`default_nettype wire

// ==== design/alloc_ctrl_regs.sv ====
/*
 * Control register block
 * Write decode of control and debug control words, reset and clear pulses
 */
`timescale 1ns/1ns
`default_nettype none

`include "alloc_cfg.svh"

module alloc_ctrl_regs (
    input  wire logic                   clk,
    input  wire logic                   dbg_cnt_reset,
    input  wire logic                   en,
    input  wire logic                   reg_wr,
    input  alloc_pkg::alloc_reg_addr_e  reg_addr,
    input  wire logic [31:0]            reg_wdata,
    output logic                        ctrl_reset,
    output logic                        ctrl_en,
    output logic                        ctrl_alloc_en,
    output logic                        dbg_clear,
    output logic                        enable_bit
);

    import alloc_pkg::*;

    logic ctrl_wr;
    logic dbg_wr;
    logic reset_req;
    logic clear_req;

    // --------------------
    // Write decode
    // --------------------
    assign ctrl_wr   = reg_wr && (reg_addr == REG_CONTROL);
    assign dbg_wr    = reg_wr && (reg_addr == REG_DBG_CONTROL);

    // Write-only pulse bits
    assign reset_req = ctrl_wr && reg_wdata[0];
    assign clear_req = dbg_wr && reg_wdata[0];

    // --------------------
    // Control bits
    // --------------------
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) begin
            enable_bit    <= 1'b0;
            ctrl_alloc_en <= 1'b0;
        end else if (ctrl_wr) begin
            enable_bit    <= reg_wdata[1];
            ctrl_alloc_en <= reg_wdata[2];
        end
    end

    // Block is enabled only when both the pin and the register agree
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) begin
            ctrl_en <= 1'b0;
        end else begin
            ctrl_en <= en && enable_bit;
        end
    end

    // --------------------
    // Reset and clear
    // --------------------
    // Function reset follows the block reset by one cycle
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) begin
            ctrl_reset <= 1'b1;
        end else begin
            ctrl_reset <= reset_req;
        end
    end

    // Counter clear on block reset, function reset or debug write
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) begin
            dbg_clear <= 1'b1;
        end else begin
            dbg_clear <= ctrl_reset || clear_req;
        end
    end

endmodule : alloc_ctrl_regs

`default_nettype wire

// ==== design/alloc_ptr_pool.sv ====
/*
 * Free-pointer pool allocator
 * Bitmap of free entries, init sweep, lowest-free search, event pulses
 */
`timescale 1ns/1ns
`default_nettype none

`include "alloc_cfg.svh"

module alloc_ptr_pool (
    input  wire logic                       clk,
    input  wire logic                       dbg_cnt_reset,
    input  wire logic                       ctrl_reset,
    input  wire logic                       ctrl_en,
    input  wire logic                       ctrl_alloc_en,
    input  wire logic                       alloc_req,
    input  wire logic                       dealloc_req,
    input  wire logic [`ALLOC_PTR_WID-1:0]  dealloc_ptr,
    output logic                            alloc_valid,
    output logic                            alloc_fail,
    output logic [`ALLOC_PTR_WID-1:0]       alloc_ptr,
    output logic                            ev_alloc,
    output logic                            ev_alloc_fail,
    output logic                            ev_alloc_err,
    output logic                            ev_dealloc,
    output logic                            ev_dealloc_fail,
    output logic                            ev_dealloc_err,
    output logic [`ALLOC_PTR_WID-1:0]       ev_ptr,
    output logic                            init_done,
    output alloc_pkg::alloc_state_e         state
);

    import alloc_pkg::*;

    // One bit per entry, set when the entry is free
    logic [`ALLOC_MAX_PTRS-1:0] free_map;
    logic [`ALLOC_PTR_WID-1:0]  sweep_idx;
    logic [`ALLOC_PTR_WID-1:0]  low_ptr;
    logic                       any_free;

    // Request outcomes for this cycle
    logic alloc_ok;
    logic alloc_nofree;
    logic alloc_bad;
    logic dealloc_ok;
    logic dealloc_off;
    logic dealloc_dup;

    // --------------------
    // Lowest free entry
    // --------------------
    // Scan from the top so the lowest set bit wins
    always_comb begin
        low_ptr = '0;
        for (int i = `ALLOC_MAX_PTRS - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                low_ptr = `ALLOC_PTR_WID'(i);
            end
        end
    end

    assign any_free = |free_map;

    // --------------------
    // Request decode
    // --------------------
    always_comb begin
        alloc_ok     = 1'b0;
        alloc_nofree = 1'b0;
        alloc_bad    = 1'b0;
        if (alloc_req) begin
            if (state != ST_RUN || !ctrl_alloc_en) begin
                alloc_bad = 1'b1;
            end else if (!any_free) begin
                alloc_nofree = 1'b1;
            end else begin
                alloc_ok = 1'b1;
            end
        end
    end

    // Dealloc checks the bitmap as it stood before this cycle
    always_comb begin
        dealloc_ok  = 1'b0;
        dealloc_off = 1'b0;
        dealloc_dup = 1'b0;
        if (dealloc_req) begin
            if (state != ST_RUN) begin
                dealloc_off = 1'b1;
            end else if (free_map[dealloc_ptr]) begin
                dealloc_dup = 1'b1;
            end else begin
                dealloc_ok = 1'b1;
            end
        end
    end

    // --------------------
    // State and pulses
    // --------------------
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset || ctrl_reset) begin
            state           <= ST_INIT;
            sweep_idx       <= '0;
            init_done       <= 1'b0;
            alloc_valid     <= 1'b0;
            alloc_fail      <= 1'b0;
            ev_alloc        <= 1'b0;
            ev_alloc_fail   <= 1'b0;
            ev_alloc_err    <= 1'b0;
            ev_dealloc      <= 1'b0;
            ev_dealloc_fail <= 1'b0;
            ev_dealloc_err  <= 1'b0;
        end else begin
            alloc_valid     <= alloc_ok;
            alloc_fail      <= alloc_nofree;
            ev_alloc        <= alloc_ok;
            ev_alloc_fail   <= alloc_nofree;
            ev_alloc_err    <= alloc_bad;
            ev_dealloc      <= dealloc_ok;
            ev_dealloc_fail <= dealloc_off;
            ev_dealloc_err  <= dealloc_dup;
            case (state)
                ST_INIT: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    // Last entry swept this cycle
                    if (&sweep_idx) begin
                        init_done <= 1'b1;
                        state     <= ctrl_en ? ST_RUN : ST_DISABLED;
                    end
                end
                ST_RUN: begin
                    if (!ctrl_en) state <= ST_DISABLED;
                end
                ST_DISABLED: begin
                    if (ctrl_en) state <= ST_RUN;
                end
                default: state <= ST_INIT;
            endcase
        end
    end

    // --------------------
    // Bitmap and pointers
    // --------------------
    always_ff @(posedge clk) begin
        if (state == ST_INIT) free_map[sweep_idx] <= 1'b1;
        if (alloc_ok) begin
            free_map[low_ptr] <= 1'b0;
            alloc_ptr         <= low_ptr;
        end
        if (dealloc_ok) free_map[dealloc_ptr] <= 1'b1;

        // Error pointers take priority on ev_ptr
        if (dealloc_dup) begin
            ev_ptr <= dealloc_ptr;
        end else if (alloc_bad) begin
            ev_ptr <= '0;
        end else if (alloc_ok) begin
            ev_ptr <= low_ptr;
        end else if (dealloc_ok) begin
            ev_ptr <= dealloc_ptr;
        end
    end

endmodule : alloc_ptr_pool

`default_nettype wire

// ==== design/alloc_pkg.sv ====
/*
 * Allocator package
 * Register word address map and allocator state encoding
 */
`default_nettype none

`include "alloc_cfg.svh"

package alloc_pkg;

    // Register word addresses
    typedef enum logic [`ALLOC_ADDR_WID-1:0] {
        REG_CONTROL              = 0,
        REG_STATUS               = 1,
        REG_STATUS_FLAGS         = 2,
        REG_ALLOC_ERR_PTR        = 3,
        REG_DEALLOC_ERR_PTR      = 4,
        REG_CNT_ACTIVE           = 5,
        REG_DBG_CONTROL          = 6,
        REG_DBG_STATUS           = 7,
        REG_INFO_SIZE            = 8,
        REG_DBG_CNT_ALLOC        = 9,
        REG_DBG_CNT_ALLOC_FAIL   = 10,
        REG_DBG_CNT_ALLOC_ERR    = 11,
        REG_DBG_CNT_DEALLOC      = 12,
        REG_DBG_CNT_DEALLOC_FAIL = 13,
        REG_DBG_CNT_DEALLOC_ERR  = 14
    } alloc_reg_addr_e;

    // Allocator state, read back through REG_DBG_STATUS
    typedef enum logic [1:0] {
        ST_INIT     = 2'd0,
        ST_RUN      = 2'd1,
        ST_DISABLED = 2'd2
    } alloc_state_e;

endpackage : alloc_pkg

`default_nettype wire

// ==== design/alloc_cfg.svh ====
/*
 * Allocator build parameters
 * Pointer width, pool size, register address width and counter width
 */
`ifndef ALLOC_CFG_SVH
`define ALLOC_CFG_SVH

// --------------------
// Pointer pool
// --------------------
// Pointer width; the pool holds 2**ALLOC_PTR_WID entries
`define ALLOC_PTR_WID 4
`define ALLOC_MAX_PTRS (1 << `ALLOC_PTR_WID)

// --------------------
// Register map
// --------------------
// Word address width of the register port
`define ALLOC_ADDR_WID 4

// Width of each debug event counter
`define ALLOC_CNT_WID 32

`endif
